// File: hdl/ising_pkg.sv
// shared sizes for the spin-flip datapath; NUM_SPIN and FLIP_ICON_DEPTH must be powers of two
package ising_pkg;

    // number of spins in one vector
    // every spin word and every icon word is this wide
    localparam int NUM_SPIN = 16;

    // number of flip icons the local memory can hold
    // software may program any icon count from zero up to this value
    localparam int FLIP_ICON_DEPTH = 16;

    // width of a word address inside the icon memory
    localparam int ICON_ADDR_W = $clog2(FLIP_ICON_DEPTH);

    // width of the read address counter and of the programmed icon count
    // one extra bit so that a count equal to the full depth can be expressed
    localparam int ICON_CNT_W = ICON_ADDR_W + 1;

    // spin handshakes that bypass mode waits for before it forces the finish flag
    // this matches the buffering depth of the spin stream around the engine
    localparam int SPIN_DEPTH = 2;

    // note that the read address is ICON_CNT_W bits wide
    // the memory only sees the low ICON_ADDR_W bits of it, so reads past the
    // programmed count wrap around the physical array

    // the icon count is compared against the full-width address
    // a count of zero therefore reports finish straight out of reset

    // all sizes here are elaboration-time constants
    // the datapath has no run-time configuration of widths

    // bypass counting uses a counter of $clog2(SPIN_DEPTH) bits
    // with SPIN_DEPTH of one the counter is left out and the first
    // bypass handshake already forces finish

endpackage

// File: hdl/step_counter.sv
// saturating step counter; restart clears it even when en_i is low, maxed_o stays high until restart
`timescale 1ns/100ps

module step_counter #(
    parameter int COUNTER_W = 2
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic en_i,
    input  logic restart_i,
    input  logic step_i,
    output logic maxed_o
);

    // current count, saturates at all ones
    logic [COUNTER_W-1:0] cnt_q;

    // the counter is full once every bit is set
    // no further steps are taken from that point on
    assign maxed_o = &cnt_q;

    // restart has priority over a step in the same cycle
    // a step only counts while the counter is enabled and not yet full
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else if (restart_i) begin
            cnt_q <= '0;
        end else if (en_i && step_i && !maxed_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // a typical use is counting handshakes on a stream
    // the caller ties step_i to the handshake and restart_i to its clear condition

    // with COUNTER_W of one the counter is a single flag
    // it goes full on the first step

    // the count itself is kept internal
    // callers only ever need to know when the limit has been hit

    // saturation keeps the count from wrapping back to zero
    // so maxed_o never drops without an explicit restart

    // en_i freezes the count but does not block restart
    // this lets a clear reach the counter while the owner is paused

endmodule

// File: hdl/bp_pipe.sv
// one-entry valid/ready register slice; ready_o depends combinationally on ready_i
`timescale 1ns/100ps

module bp_pipe (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          valid_i,
    input  logic [ising_pkg::NUM_SPIN-1:0] data_i,
    input  logic                          ready_i,
    output logic                          ready_o,
    output logic                          valid_o,
    output logic [ising_pkg::NUM_SPIN-1:0] data_o
);

    import ising_pkg::*;

    // occupancy flag of the single slot
    logic valid_q;

    // spin vector held in the slot
    logic [NUM_SPIN-1:0] data_q;

    // the slot can take a new vector when it is empty
    // or when its current vector leaves in this same cycle
    assign ready_o = !valid_q || ready_i;

    // the slot drives the downstream side directly
    assign valid_o = valid_q;
    assign data_o  = data_q;

    // the valid flag follows the upstream valid whenever the slot may load
    // otherwise it holds, which keeps the output stable under back-pressure
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    // payload only moves on an accepted input transfer
    // while stalled the held vector stays put
    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    // a transfer in lands in the slot at the edge and is visible right after it
    // so the latency through the slice is one cycle

    // a full slot with a waiting consumer passes straight through
    // the old vector leaves and the new one loads on the same edge

    // only one vector is ever in flight in this slice
    // throughput is still one per cycle as long as ready_i stays high

endmodule

// File: hdl/flip_icon_mem.sv
// icon RAM with one write and one registered read port; read of a word written the same cycle returns old data
`timescale 1ns/100ps

module flip_icon_mem (
    input  logic                             clk_i,
    input  logic                             we_i,
    input  logic [ising_pkg::ICON_ADDR_W-1:0] waddr_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]    wdata_i,
    input  logic                             ren_i,
    input  logic [ising_pkg::ICON_ADDR_W-1:0] raddr_i,
    output logic [ising_pkg::NUM_SPIN-1:0]    rdata_o
);

    import ising_pkg::*;

    // one flip mask per entry, one bit per spin
    logic [NUM_SPIN-1:0] mem [FLIP_ICON_DEPTH];

    // read data register
    // it keeps the last word read until the next read enable
    logic [NUM_SPIN-1:0] rdata_q;

    // write port
    // one word per cycle, no handshake, the loader just pulses we_i
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read port
    // the word shows up on rdata_o in the cycle after ren_i
    always_ff @(posedge clk_i) begin
        if (ren_i) begin
            rdata_q <= mem[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

    // the contents are undefined until software loads them
    // there is no reset on the array or on the read register

    // a simultaneous write and read to the same address returns the old word
    // the new word is visible from the next read on

    // holding rdata_q between reads lets the engine rely on it
    // as long as no new read enable has been issued

    // the array maps onto a plain synchronous RAM
    // both ports share the same clock

endmodule

// File: hdl/flip_engine.sv
// spin XOR engine; one vector in flight, icon count must not exceed the address range, bypass is taken live
`timescale 1ns/100ps

module flip_engine (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            en_i,
    input  logic                            flush_i,
    input  logic                            flip_disable_i,
    input  logic                            prev_spin_valid_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]   prev_spin_i,
    input  logic                            flipped_spin_ready_i,
    input  logic [ising_pkg::ICON_CNT_W-1:0] icon_last_raddr_plus_one_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]   flip_rdata_i,
    output logic                            prev_spin_ready_o,
    output logic [ising_pkg::NUM_SPIN-1:0]   flipped_spin_o,
    output logic                            flipped_spin_valid_o,
    output logic                            flip_ren_o,
    output logic [ising_pkg::ICON_CNT_W-1:0] flip_raddr_o,
    output logic                            icon_finish_o
);

    import ising_pkg::*;

    // stream handshakes
    logic prev_spin_hs;

    // read request this cycle and its delayed copy
    // the delayed copy marks the cycle in which the memory data is fresh
    logic flip_ren;
    logic flip_ren_q;

    // read address counter and the icon that was last fetched
    logic [ICON_CNT_W-1:0] flip_raddr_q;
    logic [NUM_SPIN-1:0]   flip_rdata_q;

    // mask applied to the vector in the output slot
    logic [NUM_SPIN-1:0] flip_icon;

    // spin vector sitting in the output slot
    logic [NUM_SPIN-1:0] spin_pipe;

    // finish bookkeeping
    logic icon_empty;
    logic icon_finish_q;
    logic bypass_finish_q;
    logic bypass_cnt_maxed;

    assign prev_spin_hs = prev_spin_valid_i && prev_spin_ready_o;

    // every accepted spin asks for the next icon, unless paused, flushed or bypassed
    assign flip_ren     = en_i && prev_spin_hs && !flush_i && !flip_disable_i;
    assign flip_ren_o   = flip_ren;
    assign flip_raddr_o = flip_raddr_q;

    // fresh memory data right after a read, the held copy while the output stalls
    assign flip_icon = flip_ren_q ? flip_rdata_i : flip_rdata_q;

    // bypass forwards the vector untouched
    assign flipped_spin_o = flip_disable_i ? spin_pipe : (spin_pipe ^ flip_icon);

    // all programmed icons have been read once the address reaches the count
    assign icon_empty = (flip_raddr_q == icon_last_raddr_plus_one_i);

    // the compare is visible in the same cycle, the register keeps it sticky
    assign icon_finish_o = bypass_finish_q || icon_finish_q || icon_empty;

    // address moves by one per read, flush brings it back to the first icon
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            flip_raddr_q <= '0;
        end else if (flip_ren) begin
            flip_raddr_q <= flip_raddr_q + 1'b1;
        end
    end

    // remember whether the memory output was refreshed in the last cycle
    // frozen in bypass so the held icon is still chosen correctly on return
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            flip_ren_q <= 1'b0;
        end else if (en_i && !flip_disable_i) begin
            flip_ren_q <= flip_ren;
        end
    end

    // capture the fresh icon so a stalled output keeps its mask
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            flip_rdata_q <= '0;
        end else if (en_i && flip_ren_q) begin
            flip_rdata_q <= flip_rdata_i;
        end
    end

    // once the address has hit the count the flag stays up until flush
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            icon_finish_q <= 1'b0;
        end else if (en_i && icon_empty) begin
            icon_finish_q <= 1'b1;
        end
    end

    // in bypass, finish is forced once a full buffer of spins has gone by
    // leaving bypass drops the forced flag again
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i || !flip_disable_i) begin
            bypass_finish_q <= 1'b0;
        end else if (en_i && bypass_cnt_maxed && prev_spin_hs) begin
            bypass_finish_q <= 1'b1;
        end
    end

    // count bypass handshakes up to the spin buffer depth
    generate
        if (SPIN_DEPTH > 1) begin : gen_bypass_cnt
            step_counter #(
                .COUNTER_W($clog2(SPIN_DEPTH))
            ) u_bypass_cnt (
                .clk_i     (clk_i),
                .reset_i   (reset_i),
                .en_i      (en_i),
                .restart_i (flush_i || !flip_disable_i),
                .step_i    (flip_disable_i && prev_spin_hs),
                .maxed_o   (bypass_cnt_maxed)
            );
        end else begin : gen_no_bypass_cnt
            // a single-entry buffer is covered by the first handshake
            assign bypass_cnt_maxed = 1'b1;
        end
    endgenerate

    // one-stage slice that carries the spin and the back-pressure
    bp_pipe u_spin_pipe (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .valid_i (prev_spin_valid_i),
        .data_i  (prev_spin_i),
        .ready_i (flipped_spin_ready_i),
        .ready_o (prev_spin_ready_o),
        .valid_o (flipped_spin_valid_o),
        .data_o  (spin_pipe)
    );

endmodule

// File: hdl/spin_flip_top.sv
// spin-flip subsystem top; icons must be loaded before streaming, only the low address bits reach the RAM
`timescale 1ns/100ps

module spin_flip_top (
    input  logic                             clk_i,
    input  logic                             reset_i,

    // icon load port
    input  logic                             icon_we_i,
    input  logic [ising_pkg::ICON_ADDR_W-1:0] icon_waddr_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]    icon_wdata_i,

    // control levels
    input  logic                             en_i,
    input  logic                             flush_i,
    input  logic                             flip_disable_i,
    input  logic [ising_pkg::ICON_CNT_W-1:0]  icon_count_i,

    // input spin stream
    input  logic                             prev_spin_valid_i,
    input  logic [ising_pkg::NUM_SPIN-1:0]    prev_spin_i,
    output logic                             prev_spin_ready_o,

    // output spin stream
    output logic                             flipped_spin_valid_o,
    output logic [ising_pkg::NUM_SPIN-1:0]    flipped_spin_o,
    input  logic                             flipped_spin_ready_i,

    // status
    output logic                             icon_finish_o
);

    import ising_pkg::*;

    // read request from the engine to the icon memory
    logic flip_ren;

    // full-width read address, the top bit only matters for the finish compare
    logic [ICON_CNT_W-1:0] flip_raddr;

    // icon word returned one cycle after the request
    logic [NUM_SPIN-1:0] flip_rdata;

    // the engine handles the handshakes, the address sequencing and the XOR itself
    flip_engine u_flip_engine (
        .clk_i                      (clk_i),
        .reset_i                    (reset_i),
        .en_i                       (en_i),
        .flush_i                    (flush_i),
        .flip_disable_i             (flip_disable_i),
        .prev_spin_valid_i          (prev_spin_valid_i),
        .prev_spin_i                (prev_spin_i),
        .flipped_spin_ready_i       (flipped_spin_ready_i),
        .icon_last_raddr_plus_one_i (icon_count_i),
        .flip_rdata_i               (flip_rdata),
        .prev_spin_ready_o          (prev_spin_ready_o),
        .flipped_spin_o             (flipped_spin_o),
        .flipped_spin_valid_o       (flipped_spin_valid_o),
        .flip_ren_o                 (flip_ren),
        .flip_raddr_o               (flip_raddr),
        .icon_finish_o              (icon_finish_o)
    );

    // local icon store
    // the write side belongs to the loader, the read side to the engine
    flip_icon_mem u_flip_icon_mem (
        .clk_i   (clk_i),
        .we_i    (icon_we_i),
        .waddr_i (icon_waddr_i),
        .wdata_i (icon_wdata_i),
        .ren_i   (flip_ren),
        .raddr_i (flip_raddr[ICON_ADDR_W-1:0]),
        .rdata_o (flip_rdata)
    );

    // loading while the stream is running is allowed by the RAM
    // but a word being read in the same cycle comes back with its old value

    // the engine never stalls the memory, so there is no ready on the read side
    // the one-cycle read latency is built into the engine's icon select

endmodule

// File: tests/tb_spin_flip_top.sv
// testbench for spin_flip_top; en_i stays high and control levels only change while the stream is drained
`timescale 1ns/100ps

module tb_spin_flip_top;

    import ising_pkg::*;

    // the whole sequence needs a few hundred cycles and 4000 leaves a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                   clk;
    logic                   reset;
    logic                   icon_we;
    logic [ICON_ADDR_W-1:0] icon_waddr;
    logic [NUM_SPIN-1:0]    icon_wdata;
    logic                   en;
    logic                   flush;
    logic                   flip_disable;
    logic [ICON_CNT_W-1:0]  icon_count;
    logic                   prev_spin_valid;
    logic [NUM_SPIN-1:0]    prev_spin;
    logic                   prev_spin_ready;
    logic                   flipped_spin_valid;
    logic [NUM_SPIN-1:0]    flipped_spin;
    logic                   flipped_spin_ready;
    logic                   icon_finish;

    // copy of what was written into the icon memory
    logic [NUM_SPIN-1:0] icon_copy [FLIP_ICON_DEPTH];

    // reference model state
    // flip_cnt counts flipped transfers since reset or flush, bp_cnt counts bypass transfers
    logic [NUM_SPIN-1:0] exp_q [$];
    logic [NUM_SPIN-1:0] exp_word;
    int                  flip_cnt;
    int                  bp_cnt;
    logic                exp_finish;

    string test_name;
    int    ready_pct;
    int    cycles;
    int    data_errs;
    int    order_errs;
    int    stall_errs;
    int    ready_errs;
    int    finish_errs;

    spin_flip_top DUT (
        .clk_i                (clk),
        .reset_i              (reset),
        .icon_we_i            (icon_we),
        .icon_waddr_i         (icon_waddr),
        .icon_wdata_i         (icon_wdata),
        .en_i                 (en),
        .flush_i              (flush),
        .flip_disable_i       (flip_disable),
        .icon_count_i         (icon_count),
        .prev_spin_valid_i    (prev_spin_valid),
        .prev_spin_i          (prev_spin),
        .prev_spin_ready_o    (prev_spin_ready),
        .flipped_spin_valid_o (flipped_spin_valid),
        .flipped_spin_o       (flipped_spin),
        .flipped_spin_ready_i (flipped_spin_ready),
        .icon_finish_o        (icon_finish)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // finish is due once the programmed icons are used up, or after a full buffer in bypass
    assign exp_finish = (flip_cnt >= int'(icon_count)) || (bp_cnt >= SPIN_DEPTH);

    // icons are taken in order and wrap around the physical memory
    function automatic logic [ICON_ADDR_W-1:0] icon_index(input int cnt);
        return ICON_ADDR_W'(cnt % FLIP_ICON_DEPTH);
    endfunction

    // ready_pct sets how often the downstream consumer takes a vector
    initial begin
        flipped_spin_ready = 1'b0;
        forever begin
            @(negedge clk);
            flipped_spin_ready = (($urandom % 100) < ready_pct);
        end
    end

    // the scoreboard and the reference model sample both streams at the rising edge
    always @(posedge clk) begin
        if (reset) begin
            flip_cnt = 0;
            bp_cnt   = 0;
            exp_q.delete();
        end else begin
            if (flipped_spin_valid && flipped_spin_ready) begin
                if (exp_q.size() == 0) begin
                    order_errs++;
                    $display("output transfer in test %s with no vector outstanding", test_name);
                end else begin
                    exp_word = exp_q.pop_front();
                    if (flipped_spin !== exp_word) begin
                        data_errs++;
                        $display("ERR %s: expected %h actual %h", test_name, exp_word,
                                 flipped_spin);
                    end
                end
            end
            if (prev_spin_valid && prev_spin_ready) begin
                if (flip_disable) begin
                    exp_q.push_back(prev_spin);
                end else begin
                    exp_q.push_back(prev_spin ^ icon_copy[icon_index(flip_cnt)]);
                    flip_cnt++;
                end
            end
            // the bypass count only lives while bypass is on
            if (flush || !flip_disable) begin
                bp_cnt = 0;
            end else if (prev_spin_valid && prev_spin_ready && bp_cnt < SPIN_DEPTH) begin
                bp_cnt++;
            end
            if (flush) begin
                flip_cnt = 0;
            end
        end
    end

    // a stalled output must hold both its valid and its vector
    assert property (@(posedge clk) disable iff (reset)
        (flipped_spin_valid && !flipped_spin_ready) |=>
            (flipped_spin_valid && $stable(flipped_spin)))
    else begin
        stall_errs++;
        $display("output vector or valid changed while stalled in test %s", test_name);
    end

    // the input side is open whenever the slot is empty or its vector leaves this cycle
    assert property (@(posedge clk) disable iff (reset)
        (!flipped_spin_valid || flipped_spin_ready) |-> prev_spin_ready)
    else begin
        ready_errs++;
        $display("ERR %s: prev_spin_ready_o expected 1 actual %b", test_name,
                 $sampled(prev_spin_ready));
    end

    assert property (@(posedge clk) disable iff (reset) (icon_finish == exp_finish))
    else begin
        finish_errs++;
        $display("ERR %s: icon_finish_o expected %b actual %b", test_name,
                 $sampled(exp_finish), $sampled(icon_finish));
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic load_icons;
        logic [31:0] rnd;
        for (int i = 0; i < FLIP_ICON_DEPTH; i++) begin
            @(negedge clk);
            rnd          = $urandom;
            icon_we      = 1'b1;
            icon_waddr   = ICON_ADDR_W'(i);
            icon_wdata   = rnd[NUM_SPIN-1:0];
            icon_copy[i] = rnd[NUM_SPIN-1:0];
        end
        @(negedge clk);
        icon_we = 1'b0;
    endtask

    // offers count vectors, each one held until it is accepted
    task automatic send_vectors(input int count, input int valid_pct);
        logic [31:0] rnd;
        int          sent;
        sent = 0;
        while (sent < count) begin
            @(negedge clk);
            if (($urandom % 100) < valid_pct) begin
                rnd             = $urandom;
                prev_spin_valid = 1'b1;
                prev_spin       = rnd[NUM_SPIN-1:0];
                @(posedge clk);
                while (!prev_spin_ready) begin
                    @(posedge clk);
                end
                sent++;
            end else begin
                prev_spin_valid = 1'b0;
            end
        end
        @(negedge clk);
        prev_spin_valid = 1'b0;
    endtask

    // wait until every accepted vector has left the DUT
    task automatic drain;
        @(negedge clk);
        prev_spin_valid = 1'b0;
        while (exp_q.size() != 0 || flipped_spin_valid) begin
            @(negedge clk);
        end
    endtask

    // new icon count is applied right after the flush edge
    task automatic flush_with_count(input int new_count);
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush      = 1'b0;
        icon_count = ICON_CNT_W'(new_count);
    endtask

    initial begin
        void'($urandom(96));
        reset           = 1'b1;
        icon_we         = 1'b0;
        icon_waddr      = '0;
        icon_wdata      = '0;
        en              = 1'b1;
        flush           = 1'b0;
        flip_disable    = 1'b0;
        icon_count      = ICON_CNT_W'(10);
        prev_spin_valid = 1'b0;
        prev_spin       = '0;
        ready_pct       = 100;
        test_name       = "reset";
        cycles          = 0;
        data_errs       = 0;
        order_errs      = 0;
        stall_errs      = 0;
        ready_errs      = 0;
        finish_errs     = 0;

        repeat (16) @(negedge clk);
        reset = 1'b0;

        test_name = "load";
        load_icons();

        test_name = "flip";
        send_vectors(8, 100);
        drain();

        // finish rises during this run once ten vectors have been flipped
        test_name = "backpressure";
        ready_pct = 50;
        send_vectors(24, 60);
        drain();

        test_name = "bypass";
        flush_with_count(12);
        ready_pct = 70;
        send_vectors(3, 80);
        drain();
        @(negedge clk);
        flip_disable = 1'b1;
        send_vectors(5, 70);
        drain();
        flip_disable = 1'b0;
        // flipping picks up at icon 3
        send_vectors(12, 80);
        drain();

        test_name = "flush";
        flush_with_count(5);
        ready_pct = 60;
        send_vectors(6, 70);
        drain();

        // with a count of zero finish is high straight after the flush
        test_name = "zero_count";
        flush_with_count(0);
        send_vectors(3, 90);
        drain();

        repeat (4) @(negedge clk);
        $display("errors: data %0d, order %0d, stall %0d, ready %0d, finish %0d",
                 data_errs, order_errs, stall_errs, ready_errs, finish_errs);
        if (data_errs + order_errs + stall_errs + ready_errs + finish_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/ising_pkg.sv
hdl/step_counter.sv
hdl/bp_pipe.sv
hdl/flip_icon_mem.sv
hdl/flip_engine.sv
hdl/spin_flip_top.sv
tests/tb_spin_flip_top.sv

// File: Makefile
# Verilator build and run for the spin-flip subsystem

VERILATOR  ?= verilator
TB_TOP     ?= tb_spin_flip_top
RTL_TOP    ?= spin_flip_top
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= *** PASSED ***

RTL_FILES := $(filter hdl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
